// ==== sim.f ====
+incdir+verification
rtl/csr_pkg.sv
rtl/sreg_server.sv
rtl/mmio_csr_wr.sv
rtl/mmio_csr_rd.sv
rtl/afu_csr_top.sv
verification/tb_afu_csr.sv

// ==== verification/csr_ref_model.svh ====
// Reference model of the CSR block, included inside the testbench module to predict every response
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Shadow copy of the SREG address register and the system register bank
sreg_addr_t model_sreg_addr;
mmio_data_t model_regs [SREG_COUNT];

// Outstanding SREG read with the tag and data it must come back with
logic       pend_valid;
mmio_tid_t  pend_tid;
mmio_data_t pend_data;

// Cycles that have passed since the outstanding SREG read was issued
int         pend_age;

// Everything is zero after reset and nothing is in flight
function automatic void reset_model();
    model_sreg_addr = '0;
    for (int i = 0; i < SREG_COUNT; i++)
    begin
        model_regs[i] = '0;
    end
    pend_valid = 1'b0;
    pend_tid   = '0;
    pend_data  = '0;
    pend_age   = 0;
endfunction

// A read inside the window gets a same-cycle answer unless it targets the SREG read index
function automatic logic expects_direct(input logic valid, input logic write,
                                        input mmio_addr_t addr);
    if (!valid || write || (addr >= CSR_WINDOW_LIMIT))
    begin
        return 1'b0;
    end
    return (addr[3:1] != CSR_SREG_READ);
endfunction

// Data of a same-cycle answer is built from the register map
function automatic mmio_data_t direct_value(input mmio_addr_t addr);
    csr_index_t idx;
    idx = addr[3:1];
    case (idx)
        CSR_DFH:       return {AFU_FEATURE_TYPE, 20'h0, DFH_NEXT_OFFSET, 16'h0};
        CSR_AFU_ID_L:  return DEFAULT_AFU_ID[63:0];
        CSR_AFU_ID_H:  return DEFAULT_AFU_ID[127:64];
        CSR_SREG_ADDR: return {60'h0, model_sreg_addr};
        default:       return '0;
    endcase
endfunction

// One more cycle has gone by for the outstanding SREG read
function automatic void age_pending();
    if (pend_valid)
    begin
        pend_age++;
    end
endfunction

// The bank answers SREG_LATENCY cycles after the request and the holding register
// loads in that cycle, so the result may leave from the cycle after it
// It then goes out in the first such cycle that carries no direct answer
function automatic logic pending_due(input logic direct);
    return pend_valid && (pend_age > SREG_LATENCY) && !direct;
endfunction

// Applies the state change of one request once its response has been checked
function automatic void update_model(input logic valid, input logic write,
                                     input mmio_addr_t addr, input mmio_tid_t tid,
                                     input mmio_data_t data);
    csr_index_t idx;
    idx = addr[3:1];
    if (valid && (addr < CSR_WINDOW_LIMIT))
    begin
        if (write && (idx == CSR_SREG_ADDR))
        begin
            model_sreg_addr = data[3:0];
        end
        else if (write && (idx == CSR_SREG_WDATA))
        begin
            model_regs[model_sreg_addr] = data;
        end
        else if (!write && (idx == CSR_SREG_READ))
        begin
            // The bank is not written while a read is pending, so its data is known now
            pend_valid = 1'b1;
            pend_tid   = tid;
            pend_data  = model_regs[model_sreg_addr];
            pend_age   = 0;
        end
    end
endfunction

`endif

// ==== verification/tb_afu_csr.sv ====
// Testbench for the accelerator CSR block that checks random MMIO traffic against a reference model
`timescale 1ns/10ps

module tb_afu_csr
    import csr_pkg::*;
();

    logic       clk = 1'b0;
    logic       reset_n;
    logic       req_valid;
    logic       req_write;
    mmio_addr_t req_addr;
    mmio_tid_t  req_tid;
    mmio_data_t req_data;
    logic       rsp_valid;
    mmio_tid_t  rsp_tid;
    mmio_data_t rsp_data;

    // State of the xorshift generator
    logic [31:0] rng_state = 32'd50;

    `include "csr_ref_model.svh"

    // 4 ns clock period
    always #2 clk = ~clk;

    afu_csr_top i_afu_csr_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_tid   (req_tid),
        .req_data  (req_data),
        .rsp_valid (rsp_valid),
        .rsp_tid   (rsp_tid),
        .rsp_data  (rsp_data)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "Simulation stopped on mismatch");
        end
    endtask

    // Register address for an index with bit 0 picked at random since it does not select a register
    function automatic mmio_addr_t index_addr(input csr_index_t idx);
        logic [31:0] r;
        r = next_rand();
        return {12'h0, idx, r[0]};
    endfunction

    // Any address at or above the window limit
    function automatic mmio_addr_t outside_addr();
        logic [31:0] r;
        r = next_rand();
        if (r[15:0] < CSR_WINDOW_LIMIT)
        begin
            return r[15:0] + CSR_WINDOW_LIMIT;
        end
        return r[15:0];
    endfunction

    // Drives one request cycle on the falling edge and checks the response before the rising edge
    task automatic run_cycle(input logic valid, input logic write, input mmio_addr_t addr,
                             input mmio_tid_t tid, input mmio_data_t data);
        logic direct;
        logic hold_due;
        @(negedge clk);
        req_valid = valid;
        req_write = write;
        req_addr  = addr;
        req_tid   = tid;
        req_data  = data;
        #1;
        direct = expects_direct(valid, write, addr);
        age_pending();
        hold_due = pending_due(direct);
        if (direct)
        begin
            // A direct answer always wins the response port
            check_value("rsp_valid", rsp_valid, 1);
            check_value("rsp_tid", rsp_tid, tid);
            check_value("rsp_data", rsp_data, direct_value(addr));
        end
        else
        begin
            // Only the parked SREG result may answer here, and only when it is due
            check_value("rsp_valid", rsp_valid, hold_due);
            if (hold_due)
            begin
                check_value("rsp_tid", rsp_tid, pend_tid);
                check_value("rsp_data", rsp_data, pend_data);
                pend_valid = 1'b0;
            end
        end
        update_model(valid, write, addr, tid, data);
    endtask

    // Idle cycle with random junk on the request lines while valid is low
    task automatic idle_cycle();
        logic [31:0] r;
        r = next_rand();
        run_cycle(1'b0, r[0], r[31:16], r[8:0], {next_rand(), next_rand()});
    endtask

    task automatic direct_read(input csr_index_t idx);
        logic [31:0] r;
        r = next_rand();
        run_cycle(1'b1, 1'b0, index_addr(idx), r[8:0], {next_rand(), next_rand()});
    endtask

    task automatic csr_write(input csr_index_t idx, input mmio_data_t data);
        logic [31:0] r;
        r = next_rand();
        run_cycle(1'b1, 1'b1, index_addr(idx), r[8:0], data);
    endtask

    // Issues an SREG read and waits for its answer while direct reads fill the gap when busy is set
    task automatic sreg_read(input logic busy);
        logic [31:0] r;
        csr_index_t  idx;
        int          cycles;
        direct_read(CSR_SREG_READ);
        cycles = 0;
        while (pend_valid)
        begin
            if (cycles == 50)
            begin
                report_failure("SREG read response never arrived within 50 cycles");
            end
            r = next_rand();
            idx = r[3:1];
            // A second SREG read must wait for this one to finish
            if (idx == CSR_SREG_READ)
            begin
                idx = CSR_DFH;
            end
            if (busy && r[0])
            begin
                direct_read(idx);
            end
            else
            begin
                idle_cycle();
            end
            cycles++;
        end
    endtask

    initial
    begin
        logic [31:0] r;
        reset_n   = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_tid   = '0;
        req_data  = '0;
        reset_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        #1;
        check_value("rsp_valid", rsp_valid, 0);

        // Right after reset every system register reads zero
        for (int i = 0; i < 4; i++)
        begin
            csr_write(CSR_SREG_ADDR, {next_rand(), next_rand()});
            sreg_read(1'b0);
        end

        // Header, identifier and reserved words
        for (int i = 0; i < 40; i++)
        begin
            r = next_rand();
            direct_read(csr_index_t'(r % 5));
        end

        // Address register read back and write-only data port
        for (int i = 0; i < 10; i++)
        begin
            csr_write(CSR_SREG_ADDR, {next_rand(), next_rand()});
            direct_read(CSR_SREG_ADDR);
            direct_read(CSR_SREG_WDATA);
        end

        // Indirect writes followed by reads of random registers
        for (int i = 0; i < 24; i++)
        begin
            csr_write(CSR_SREG_ADDR, {next_rand(), next_rand()});
            csr_write(CSR_SREG_WDATA, {next_rand(), next_rand()});
            csr_write(CSR_SREG_ADDR, {next_rand(), next_rand()});
            sreg_read(1'b0);
        end

        // SREG reads overlapped by direct reads
        for (int i = 0; i < 12; i++)
        begin
            csr_write(CSR_SREG_ADDR, {next_rand(), next_rand()});
            sreg_read(1'b1);
        end

        // Mixed traffic including requests outside the window
        for (int i = 0; i < 300; i++)
        begin
            r = next_rand();
            case (r[2:0])
                3'd0, 3'd1, 3'd2: direct_read(r[5:3] == CSR_SREG_READ ? CSR_DFH : r[5:3]);
                3'd3: csr_write(r[5:3] == CSR_SREG_READ ? CSR_SREG_WDATA : r[5:3],
                                {next_rand(), next_rand()});
                3'd4: sreg_read(r[6]);
                3'd5, 3'd6: run_cycle(1'b1, r[7], outside_addr(), r[16:8],
                                      {next_rand(), next_rand()});
                default: idle_cycle();
            endcase
        end

        idle_cycle();
        idle_cycle();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== rtl/afu_csr_top.sv ====
// Accelerator CSR block top level: ties the host register channel to the read, write and SREG blocks
`timescale 1ns/10ps

module afu_csr_top
    import csr_pkg::*;
#(
    // Identifier reported through AFU_ID_L and AFU_ID_H
    parameter logic [127:0] afu_id = DEFAULT_AFU_ID
)
(
    input  logic       clk,
    input  logic       reset_n,

    // Host request channel, one-cycle valid, no back-pressure
    input  logic       req_valid,
    input  logic       req_write,
    input  mmio_addr_t req_addr,
    input  mmio_tid_t  req_tid,
    input  mmio_data_t req_data,

    // Host response channel, one cycle per read answer
    output logic       rsp_valid,
    output mmio_tid_t  rsp_tid,
    output mmio_data_t rsp_data
);

    // SREG address register output, used by both reads and writes
    sreg_addr_t sreg_addr;

    // SREG write strobe and data from the write side
    logic       sreg_wr_en;
    mmio_data_t sreg_wdata;

    // SREG read request and its answer
    logic       sreg_rd_req;
    logic       sreg_rsp_valid;
    mmio_data_t sreg_rsp_data;

    // Read decoder and response path
    mmio_csr_rd #(
        .afu_id         (afu_id)
    ) i_mmio_csr_rd (
        .clk            (clk),
        .reset_n        (reset_n),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_tid        (req_tid),
        .sreg_addr_cur  (sreg_addr),
        .sreg_rd_req    (sreg_rd_req),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data),
        .rsp_valid      (rsp_valid),
        .rsp_tid        (rsp_tid),
        .rsp_data       (rsp_data)
    );

    // Write decoder, owns the SREG address register
    mmio_csr_wr i_mmio_csr_wr (
        .clk            (clk),
        .reset_n        (reset_n),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .sreg_addr      (sreg_addr),
        .sreg_wr_en     (sreg_wr_en),
        .sreg_wdata     (sreg_wdata)
    );

    // System register bank behind the indirect window
    sreg_server i_sreg_server (
        .clk            (clk),
        .reset_n        (reset_n),
        .rd_req         (sreg_rd_req),
        .addr           (sreg_addr),
        .wr_en          (sreg_wr_en),
        .wdata          (sreg_wdata),
        .rsp_valid      (sreg_rsp_valid),
        .rsp_data       (sreg_rsp_data)
    );

endmodule

// ==== rtl/mmio_csr_rd.sv ====
// MMIO read side of the CSR block: answers local registers at once and returns deferred SREG reads
`timescale 1ns/10ps

module mmio_csr_rd
    import csr_pkg::*;
#(
    // 128-bit accelerator identifier reported through AFU_ID_L/H
    parameter logic [127:0] afu_id = DEFAULT_AFU_ID
)
(
    input  logic       clk,
    input  logic       reset_n,

    // Host request channel, shared with the write side
    input  logic       req_valid,
    input  logic       req_write,
    input  mmio_addr_t req_addr,
    input  mmio_tid_t  req_tid,

    // Current SREG address, held by the write side
    input  sreg_addr_t sreg_addr_cur,

    // SREG read request and its delayed answer
    output logic       sreg_rd_req,
    input  logic       sreg_rsp_valid,
    input  mmio_data_t sreg_rsp_data,

    // Response channel back to the host
    output logic       rsp_valid,
    output mmio_tid_t  rsp_tid,
    output mmio_data_t rsp_data
);

    // A read request that falls inside this block's window
    logic       rd_hit;
    csr_index_t rd_index;

    // Same-cycle answer for the local registers
    logic       direct_rsp;
    mmio_data_t direct_data;

    // Holding register for the SREG result and the tag of its request
    logic       hold_valid;
    mmio_data_t hold_data;
    mmio_tid_t  hold_tid;
    logic       hold_send;

    assign rd_hit = req_valid && !req_write && (req_addr < CSR_WINDOW_LIMIT);

    // Registers are 8 bytes wide, so address bit 0 does not select one
    assign rd_index = req_addr[3:1];

    always_comb
    begin
        direct_rsp  = 1'b0;
        direct_data = '0;

        if (rd_hit)
        begin
            case (rd_index)
                CSR_DFH:
                begin
                    direct_rsp  = 1'b1;
                    direct_data = afu_dfh_value();
                end
                CSR_AFU_ID_L:
                begin
                    direct_rsp  = 1'b1;
                    direct_data = afu_id[63:0];
                end
                CSR_AFU_ID_H:
                begin
                    direct_rsp  = 1'b1;
                    direct_data = afu_id[127:64];
                end
                CSR_RSVD0, CSR_RSVD1:
                begin
                    // Reserved words read as zero
                    direct_rsp = 1'b1;
                end
                CSR_SREG_ADDR:
                begin
                    direct_rsp  = 1'b1;
                    direct_data = mmio_data_t'(sreg_addr_cur);
                end
                CSR_SREG_WDATA:
                begin
                    // The write data port is write only and reads back zero
                    direct_rsp = 1'b1;
                end
                default:
                begin
                    // SREG read answers later through the holding register
                    direct_rsp = 1'b0;
                end
            endcase
        end
    end

    // Kick off a system register read at the current SREG address
    assign sreg_rd_req = rd_hit && (rd_index == CSR_SREG_READ);

    // A direct answer owns the port; the parked SREG result waits for an idle cycle
    assign hold_send = hold_valid && !direct_rsp;

    assign rsp_valid = direct_rsp || hold_send;
    assign rsp_tid   = hold_send ? hold_tid : req_tid;
    assign rsp_data  = hold_send ? hold_data : direct_data;

    // Remember which request the SREG data belongs to
    always_ff @(posedge clk)
    begin
        if (sreg_rd_req)
        begin
            hold_tid <= req_tid;
        end
    end

    // Park the SREG result until the response port is free
    always_ff @(posedge clk)
    begin
        if (sreg_rsp_valid)
        begin
            hold_data <= sreg_rsp_data;
        end
    end

    // Only one SREG read is outstanding, so load and send never overlap
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            hold_valid <= 1'b0;
        end
        else if (sreg_rsp_valid)
        begin
            hold_valid <= 1'b1;
        end
        else if (hold_send)
        begin
            hold_valid <= 1'b0;
        end
    end

endmodule

// ==== rtl/mmio_csr_wr.sv ====
// MMIO write side of the CSR block: holds the SREG address and issues SREG write strobes
`timescale 1ns/10ps

module mmio_csr_wr
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Host request channel, shared with the read side
    input  logic       req_valid,
    input  logic       req_write,
    input  mmio_addr_t req_addr,
    input  mmio_data_t req_data,

    // SREG address, also read back through the read side
    output sreg_addr_t sreg_addr,

    // One-cycle write strobe into the SREG bank with its data
    output logic       sreg_wr_en,
    output mmio_data_t sreg_wdata
);

    // A write request that falls inside this block's window
    logic       wr_hit;
    csr_index_t wr_index;

    assign wr_hit   = req_valid && req_write && (req_addr < CSR_WINDOW_LIMIT);
    assign wr_index = req_addr[3:1];

    // SREG address register, only the low four data bits are kept
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sreg_addr <= '0;
        end
        else if (wr_hit && (wr_index == CSR_SREG_ADDR))
        begin
            sreg_addr <= req_data[3:0];
        end
    end

    // Write strobe is high for exactly the cycle after the MMIO write
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sreg_wr_en <= 1'b0;
        end
        else
        begin
            sreg_wr_en <= wr_hit && (wr_index == CSR_SREG_WDATA);
        end
    end

    // Payload travels alongside the strobe
    always_ff @(posedge clk)
    begin
        if (wr_hit && (wr_index == CSR_SREG_WDATA))
        begin
            sreg_wdata <= req_data;
        end
    end

endmodule

// ==== rtl/sreg_server.sv ====
// System register bank with single-cycle writes and fixed-latency pipelined reads
`timescale 1ns/10ps

module sreg_server
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Read request, one-cycle pulse
    input  logic       rd_req,

    // Register address, shared by reads and writes
    input  sreg_addr_t addr,

    // Write strobe and data
    input  logic       wr_en,
    input  mmio_data_t wdata,

    // Read answer, SREG_LATENCY cycles after rd_req
    output logic       rsp_valid,
    output mmio_data_t rsp_data
);

    // The register bank itself
    mmio_data_t regs [SREG_COUNT];

    // Read pipeline, one stage per cycle of latency
    logic       rd_valid_pipe [SREG_LATENCY];
    sreg_addr_t rd_addr_pipe  [SREG_LATENCY];

    // Bank is cleared so never-written registers read zero
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < SREG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[addr] <= wdata;
        end
    end

    // Valid bits shift every cycle, so several reads may be in flight
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < SREG_LATENCY; i++)
            begin
                rd_valid_pipe[i] <= 1'b0;
            end
        end
        else
        begin
            rd_valid_pipe[0] <= rd_req;
            for (int i = 1; i < SREG_LATENCY; i++)
            begin
                rd_valid_pipe[i] <= rd_valid_pipe[i-1];
            end
        end
    end

    // Addresses follow the valid bits
    always_ff @(posedge clk)
    begin
        rd_addr_pipe[0] <= addr;
        for (int i = 1; i < SREG_LATENCY; i++)
        begin
            rd_addr_pipe[i] <= rd_addr_pipe[i-1];
        end
    end

    // The bank is read at the end of the pipeline, so earlier writes are seen
    assign rsp_valid = rd_valid_pipe[SREG_LATENCY-1];
    assign rsp_data  = regs[rd_addr_pipe[SREG_LATENCY-1]];

endmodule

// ==== rtl/csr_pkg.sv ====
// Shared CSR address map, data types, feature header layout and SREG timing, imported by the RTL
package csr_pkg;

    // MMIO request address in 4-byte units
    typedef logic [15:0] mmio_addr_t;

    // Host transaction tag carried by every request and echoed in its response
    typedef logic [8:0]  mmio_tid_t;

    // Register read and write data
    typedef logic [63:0] mmio_data_t;

    // Local register index, taken from address bits 3:1 (8-byte registers)
    typedef logic [2:0]  csr_index_t;

    // System register address inside the SREG bank
    typedef logic [3:0]  sreg_addr_t;

    // Requests at or above this address belong to some other block
    localparam mmio_addr_t CSR_WINDOW_LIMIT = 16'd16;

    // Local register indices
    localparam csr_index_t CSR_DFH        = 3'd0;
    localparam csr_index_t CSR_AFU_ID_L   = 3'd1;
    localparam csr_index_t CSR_AFU_ID_H   = 3'd2;
    localparam csr_index_t CSR_RSVD0      = 3'd3;
    localparam csr_index_t CSR_RSVD1      = 3'd4;
    localparam csr_index_t CSR_SREG_READ  = 3'd5;
    localparam csr_index_t CSR_SREG_ADDR  = 3'd6;
    localparam csr_index_t CSR_SREG_WDATA = 3'd7;

    // Constant fields of the device feature header
    localparam logic [3:0]  AFU_FEATURE_TYPE = 4'h1;
    localparam logic [23:0] DFH_NEXT_OFFSET  = 24'h001000;

    // Identifier reported when the top level is not given its own
    localparam logic [127:0] DEFAULT_AFU_ID = 128'h5d3c_9a71_0e42_4b8f_a6c1_27e9_b03f_8d14;

    // Size of the system register bank
    localparam int SREG_COUNT = 16;

    // Cycles from a system register read request to its response
    localparam int SREG_LATENCY = 4;

    // Builds the feature header word
    // Feature type lives in bits 63:60, next offset in bits 39:16, all else zero
    function automatic mmio_data_t afu_dfh_value();
        mmio_data_t dfh;
        dfh = '0;
        dfh[63:60] = AFU_FEATURE_TYPE;
        dfh[39:16] = DFH_NEXT_OFFSET;
        return dfh;
    endfunction

endpackage
